/* rtl/dispatchPkg.sv */
package dispatchPkg;

  // default machine configuration that the dispatch parameters can override.
  parameter int DefaultDispatchWidth = 4;    // instructions per dispatch group.

  // one checkpoint per unresolved branch, so this is also the mask width.
  parameter int DefaultCheckpoints = 8;

  parameter int DefaultLsqSize = 16;         // entries in each of the load and store queues.
  parameter int DefaultIssueQueueSize = 32;
  parameter int DefaultActiveListSize = 64;  // reorder window of the back end.

  // instruction address as fetched.
  typedef logic [31:0] pcT;

  // the opcode is carried through untouched because dispatch never decodes it.
  typedef logic [7:0] opcodeT;

  typedef logic [4:0] logRegT;   // architectural register number.

  // physical register tags after rename cover 128 registers in the default core.
  typedef logic [6:0] physRegT;

endpackage

/* rtl/resourceCheck.sv */
module resourceCheck #(
  parameter int DispatchWidth = dispatchPkg::DefaultDispatchWidth,
  parameter int LsqSize = dispatchPkg::DefaultLsqSize,
  parameter int IssueQueueSize = dispatchPkg::DefaultIssueQueueSize,
  parameter int ActiveListSize = dispatchPkg::DefaultActiveListSize
) (
  input  logic [DispatchWidth-1:0]          isLoad_i,   // one flag per lane.
  input  logic [DispatchWidth-1:0]          isStore_i,
  input  logic [$clog2(LsqSize):0]          loadQueueCnt_i,
  input  logic [$clog2(LsqSize):0]          storeQueueCnt_i,
  input  logic [$clog2(IssueQueueSize):0]   issueQueueCnt_i,
  input  logic [$clog2(ActiveListSize):0]   activeListCnt_i,
  output logic                              stallFrontEnd_o
);

  // a count port holds 0 up to the full size, hence the extra bit.
  localparam int LsqCntW = $clog2(LsqSize) + 1;
  localparam int IqCntW = $clog2(IssueQueueSize) + 1;
  localparam int AlCntW = $clog2(ActiveListSize) + 1;
  localparam int LaneCntW = $clog2(DispatchWidth + 1);  // holds 0 to DispatchWidth.

  // each sum gets one bit more than its widest operand so it cannot wrap.
  localparam int LsqSumW = ((LsqCntW > LaneCntW) ? LsqCntW : LaneCntW) + 1;
  localparam int IqSumW = ((IqCntW > LaneCntW) ? IqCntW : LaneCntW) + 1;
  localparam int AlSumW = ((AlCntW > LaneCntW) ? AlCntW : LaneCntW) + 1;

  logic [LaneCntW-1:0] loadCnt;
  logic [LaneCntW-1:0] storeCnt;
  logic [LsqSumW-1:0]  loadTotal;
  logic [LsqSumW-1:0]  storeTotal;
  logic [IqSumW-1:0]   issueTotal;
  logic [AlSumW-1:0]   activeTotal;
  logic                loadStall;
  logic                storeStall;
  logic                issueStall;
  logic                activeStall;

  // population count of the memory operations in the group.
  always_comb begin
    loadCnt = '0;
    storeCnt = '0;
    for (int lane = 0; lane < DispatchWidth; lane++) begin
      loadCnt = loadCnt + LaneCntW'(isLoad_i[lane]);
      storeCnt = storeCnt + LaneCntW'(isStore_i[lane]);
    end
  end

  // only the memory operations take an entry in the load and store queues.
  assign loadTotal = LsqSumW'(loadQueueCnt_i) + LsqSumW'(loadCnt);
  assign storeTotal = LsqSumW'(storeQueueCnt_i) + LsqSumW'(storeCnt);

  // The issue queue and the active list reserve the full group width.
  // This keeps the check off the per-lane decode path.
  assign issueTotal = IqSumW'(issueQueueCnt_i) + IqSumW'(DispatchWidth);
  assign activeTotal = AlSumW'(activeListCnt_i) + AlSumW'(DispatchWidth);

  assign loadStall = (loadTotal > LsqSumW'(LsqSize));
  assign storeStall = (storeTotal > LsqSumW'(LsqSize));
  assign issueStall = (issueTotal > IqSumW'(IssueQueueSize));
  assign activeStall = (activeTotal > AlSumW'(ActiveListSize));

  // the group goes as a whole, so any one full structure holds all of it.
  assign stallFrontEnd_o = loadStall | storeStall | issueStall | activeStall;

endmodule

/* rtl/branchMaskUpdate.sv */
module branchMaskUpdate #(
  parameter int DispatchWidth = dispatchPkg::DefaultDispatchWidth,
  parameter int Checkpoints = dispatchPkg::DefaultCheckpoints,
  parameter int IdW = (Checkpoints > 1) ? $clog2(Checkpoints) : 1
) (
  input  logic [DispatchWidth-1:0][Checkpoints-1:0] branchMask_i,
  input  logic                                      ctrlVerified_i,    // branch resolved correctly.
  input  logic [IdW-1:0]                            ctrlVerifiedId_i,
  output logic [DispatchWidth-1:0][Checkpoints-1:0] branchMask_o
);

  logic [Checkpoints-1:0] clearMask;

  // One-hot select of the checkpoint that was just freed.
  // It stays all zero when no branch resolves this cycle.
  always_comb begin
    clearMask = '0;
    for (int bitIdx = 0; bitIdx < Checkpoints; bitIdx++) begin
      if (ctrlVerified_i && (IdW'(bitIdx) == ctrlVerifiedId_i)) begin
        clearMask[bitIdx] = 1'b1;
      end
    end
  end

  // A group held behind a stall still sees the resolution.
  // Its masks leave with the bit already cleared.
  always_comb begin
    for (int lane = 0; lane < DispatchWidth; lane++) begin
      branchMask_o[lane] = branchMask_i[lane] & ~clearMask;  // same branch for every lane.
    end
  end

endmodule

/* rtl/dispatch.sv */
module dispatch #(
  parameter int DispatchWidth = dispatchPkg::DefaultDispatchWidth,
  parameter int Checkpoints = dispatchPkg::DefaultCheckpoints,
  parameter int LsqSize = dispatchPkg::DefaultLsqSize,
  parameter int IssueQueueSize = dispatchPkg::DefaultIssueQueueSize,
  parameter int ActiveListSize = dispatchPkg::DefaultActiveListSize,
  parameter int IdW = (Checkpoints > 1) ? $clog2(Checkpoints) : 1
) (
  input  logic                                      renameReady_i,    // rename holds a group.
  input  logic                                      flagRecoverEX_i,  // misprediction recovery.
  input  logic                                      ctrlVerified_i,
  input  logic [IdW-1:0]                            ctrlVerifiedId_i,
  input  logic [$clog2(LsqSize):0]                  loadQueueCnt_i,
  input  logic [$clog2(LsqSize):0]                  storeQueueCnt_i,
  input  logic [$clog2(IssueQueueSize):0]           issueQueueCnt_i,
  input  logic [$clog2(ActiveListSize):0]           activeListCnt_i,

  // per-lane fields of the renamed group where lane 0 is the oldest instruction.
  input  dispatchPkg::opcodeT  [DispatchWidth-1:0]  opcode_i,
  input  dispatchPkg::pcT      [DispatchWidth-1:0]  pc_i,
  input  dispatchPkg::logRegT  [DispatchWidth-1:0]  logDest_i,
  input  dispatchPkg::physRegT [DispatchWidth-1:0]  physDest_i,
  input  dispatchPkg::physRegT [DispatchWidth-1:0]  physSrc1_i,
  input  dispatchPkg::physRegT [DispatchWidth-1:0]  physSrc2_i,
  input  logic [DispatchWidth-1:0][Checkpoints-1:0] branchMask_i,
  input  logic [DispatchWidth-1:0]                  isLoad_i,
  input  logic [DispatchWidth-1:0]                  isStore_i,

  // fields toward the issue queue, active list and load-store queue.
  output dispatchPkg::opcodeT  [DispatchWidth-1:0]  opcode_o,
  output dispatchPkg::pcT      [DispatchWidth-1:0]  pc_o,
  output dispatchPkg::logRegT  [DispatchWidth-1:0]  logDest_o,
  output dispatchPkg::physRegT [DispatchWidth-1:0]  physDest_o,
  output dispatchPkg::physRegT [DispatchWidth-1:0]  physSrc1_o,
  output dispatchPkg::physRegT [DispatchWidth-1:0]  physSrc2_o,
  output logic [DispatchWidth-1:0]                  isLoad_o,
  output logic [DispatchWidth-1:0]                  isStore_o,

  // the updated masks are also written back to the rename pipeline register on a stall.
  output logic [DispatchWidth-1:0][Checkpoints-1:0] branchMask_o,
  output logic                                      backEndReady_o,
  output logic                                      stallFrontEnd_o
);

  logic stallFrontEnd;

  resourceCheck #(
    .DispatchWidth  (DispatchWidth),
    .LsqSize        (LsqSize),
    .IssueQueueSize (IssueQueueSize),
    .ActiveListSize (ActiveListSize)
  ) resourceCheck_inst (
    .isLoad_i        (isLoad_i),
    .isStore_i       (isStore_i),
    .loadQueueCnt_i  (loadQueueCnt_i),
    .storeQueueCnt_i (storeQueueCnt_i),
    .issueQueueCnt_i (issueQueueCnt_i),
    .activeListCnt_i (activeListCnt_i),
    .stallFrontEnd_o (stallFrontEnd)
  );

  branchMaskUpdate #(
    .DispatchWidth (DispatchWidth),
    .Checkpoints   (Checkpoints),
    .IdW           (IdW)
  ) branchMaskUpdate_inst (
    .branchMask_i     (branchMask_i),
    .ctrlVerified_i   (ctrlVerified_i),
    .ctrlVerifiedId_i (ctrlVerifiedId_i),
    .branchMask_o     (branchMask_o)
  );

  // The group is written into the back end only when everything lines up.
  // There must be room, a group from rename, and no recovery in progress.
  assign backEndReady_o = ~stallFrontEnd & renameReady_i & ~flagRecoverEX_i;
  assign stallFrontEnd_o = stallFrontEnd;  // holds the instruction buffer and rename.

  // the remaining fields go to the back end as they came from rename.
  assign opcode_o = opcode_i;
  assign pc_o = pc_i;              // kept by the active list for recovery.
  assign logDest_o = logDest_i;
  assign physDest_o = physDest_i;
  assign physSrc1_o = physSrc1_i;  // source tags for the issue queue wakeup.
  assign physSrc2_o = physSrc2_i;
  assign isLoad_o = isLoad_i;
  assign isStore_o = isStore_i;

endmodule

/* sim/dispatchTb.sv */
module dispatchTb;

  import dispatchPkg::*;

  localparam int DispatchWidth = DefaultDispatchWidth;
  localparam int Checkpoints = DefaultCheckpoints;
  localparam int LsqSize = DefaultLsqSize;
  localparam int IssueQueueSize = DefaultIssueQueueSize;
  localparam int ActiveListSize = DefaultActiveListSize;
  localparam int IdW = (Checkpoints > 1) ? $clog2(Checkpoints) : 1;
  localparam int LsqCntW = $clog2(LsqSize) + 1;
  localparam int IqCntW = $clog2(IssueQueueSize) + 1;
  localparam int AlCntW = $clog2(ActiveListSize) + 1;
  localparam int ResetCycles = 5;
  localparam int ResetTimeout = 50;  // cycles allowed for reset to drop.

  logic clk = 1'b0;
  logic reset_i = 1'b1;  // only paces the stimulus because the DUT has no state.
  logic renameReady_i;
  logic flagRecoverEX_i;
  logic ctrlVerified_i;
  logic [IdW-1:0] ctrlVerifiedId_i;
  logic [LsqCntW-1:0] loadQueueCnt_i;
  logic [LsqCntW-1:0] storeQueueCnt_i;
  logic [IqCntW-1:0] issueQueueCnt_i;
  logic [AlCntW-1:0] activeListCnt_i;
  opcodeT [DispatchWidth-1:0] opcode_i;
  pcT [DispatchWidth-1:0] pc_i;
  logRegT [DispatchWidth-1:0] logDest_i;
  physRegT [DispatchWidth-1:0] physDest_i;
  physRegT [DispatchWidth-1:0] physSrc1_i;
  physRegT [DispatchWidth-1:0] physSrc2_i;
  logic [DispatchWidth-1:0][Checkpoints-1:0] branchMask_i;
  logic [DispatchWidth-1:0] isLoad_i;
  logic [DispatchWidth-1:0] isStore_i;

  opcodeT [DispatchWidth-1:0] opcode_o;
  pcT [DispatchWidth-1:0] pc_o;
  logRegT [DispatchWidth-1:0] logDest_o;
  physRegT [DispatchWidth-1:0] physDest_o;
  physRegT [DispatchWidth-1:0] physSrc1_o;
  physRegT [DispatchWidth-1:0] physSrc2_o;
  logic [DispatchWidth-1:0] isLoad_o;
  logic [DispatchWidth-1:0] isStore_o;
  logic [DispatchWidth-1:0][Checkpoints-1:0] branchMask_o;
  logic backEndReady_o;
  logic stallFrontEnd_o;

  logic [31:0] lcgState = 32'h8dbf;

  always #4 clk = ~clk;

  initial begin
    repeat (ResetCycles) @(posedge clk);
    reset_i <= 1'b0;
  end

  dispatch dispatch_inst (
    .renameReady_i    (renameReady_i),
    .flagRecoverEX_i  (flagRecoverEX_i),
    .ctrlVerified_i   (ctrlVerified_i),
    .ctrlVerifiedId_i (ctrlVerifiedId_i),
    .loadQueueCnt_i   (loadQueueCnt_i),
    .storeQueueCnt_i  (storeQueueCnt_i),
    .issueQueueCnt_i  (issueQueueCnt_i),
    .activeListCnt_i  (activeListCnt_i),
    .opcode_i         (opcode_i),
    .pc_i             (pc_i),
    .logDest_i        (logDest_i),
    .physDest_i       (physDest_i),
    .physSrc1_i       (physSrc1_i),
    .physSrc2_i       (physSrc2_i),
    .branchMask_i     (branchMask_i),
    .isLoad_i         (isLoad_i),
    .isStore_i        (isStore_i),
    .opcode_o         (opcode_o),
    .pc_o             (pc_o),
    .logDest_o        (logDest_o),
    .physDest_o       (physDest_o),
    .physSrc1_o       (physSrc1_o),
    .physSrc2_o       (physSrc2_o),
    .isLoad_o         (isLoad_o),
    .isStore_o        (isStore_o),
    .branchMask_o     (branchMask_o),
    .backEndReady_o   (backEndReady_o),
    .stallFrontEnd_o  (stallFrontEnd_o)
  );

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  function automatic int randBelow(input int n);
    logic [31:0] r;
    r = nextRand();
    return int'(r % 32'(n));
  endfunction

  function automatic int countFlags(input logic [DispatchWidth-1:0] flags);
    int n;
    n = 0;
    for (int lane = 0; lane < DispatchWidth; lane++) begin
      if (flags[lane]) n++;
    end
    return n;
  endfunction

  // the back end overflows when any structure cannot take the whole group.
  function automatic logic expectStall(input int lq, input int sq, input int iq, input int al,
                                       input logic [DispatchWidth-1:0] loads,
                                       input logic [DispatchWidth-1:0] stores);
    logic stall;
    stall = (lq + countFlags(loads) > LsqSize) || (sq + countFlags(stores) > LsqSize);
    stall = stall || (iq + DispatchWidth > IssueQueueSize);  // full width is reserved.
    stall = stall || (al + DispatchWidth > ActiveListSize);
    return stall;
  endfunction

  task automatic checkValue(input string name, input logic [63:0] actual,
                            input logic [63:0] expected);
    if (actual !== expected) begin
      $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      $display("Errors found");
      $fatal(1, "stopped at the first wrong value");
    end
  endtask

  task automatic waitResetRelease();
    int cycles;
    cycles = 0;
    while (reset_i && cycles < ResetTimeout) begin
      @(posedge clk);
      cycles++;
    end
    if (reset_i) begin
      $display("Errors found");
      $fatal(1, "reset was never released");
    end
  endtask

  task automatic driveIdle();
    renameReady_i <= 1'b0;
    flagRecoverEX_i <= 1'b0;
    ctrlVerified_i <= 1'b0;
    ctrlVerifiedId_i <= '0;
    loadQueueCnt_i <= '0;
    storeQueueCnt_i <= '0;
    issueQueueCnt_i <= '0;
    activeListCnt_i <= '0;
    opcode_i <= '0;
    pc_i <= '0;
    logDest_i <= '0;
    physDest_i <= '0;
    physSrc1_i <= '0;
    physSrc2_i <= '0;
    branchMask_i <= '0;
    isLoad_i <= '0;
    isStore_i <= '0;
  endtask

  // three LCG draws fill one lane.
  task automatic driveRandomFields();
    logic [31:0] r;
    opcodeT [DispatchWidth-1:0] opc;
    pcT [DispatchWidth-1:0] pcs;
    logRegT [DispatchWidth-1:0] ldst;
    physRegT [DispatchWidth-1:0] pdst;
    physRegT [DispatchWidth-1:0] src1;
    physRegT [DispatchWidth-1:0] src2;
    logic [DispatchWidth-1:0][Checkpoints-1:0] masks;
    logic [DispatchWidth-1:0] loads;
    logic [DispatchWidth-1:0] stores;
    for (int lane = 0; lane < DispatchWidth; lane++) begin
      r = nextRand();
      opc[lane] = r[7:0];
      ldst[lane] = r[12:8];
      pdst[lane] = r[19:13];
      src1[lane] = r[26:20];
      loads[lane] = r[27];
      stores[lane] = r[28];
      r = nextRand();
      src2[lane] = r[6:0];
      masks[lane] = Checkpoints'(r >> 8);
      pcs[lane] = nextRand();
    end
    opcode_i <= opc;
    pc_i <= pcs;
    logDest_i <= ldst;
    physDest_i <= pdst;
    physSrc1_i <= src1;
    physSrc2_i <= src2;
    branchMask_i <= masks;
    isLoad_i <= loads;
    isStore_i <= stores;
  endtask

  task automatic checkPassThrough();
    for (int lane = 0; lane < DispatchWidth; lane++) begin
      checkValue($sformatf("opcode_o[%0d]", lane), 64'(opcode_o[lane]), 64'(opcode_i[lane]));
      checkValue($sformatf("pc_o[%0d]", lane), 64'(pc_o[lane]), 64'(pc_i[lane]));
      checkValue($sformatf("logDest_o[%0d]", lane), 64'(logDest_o[lane]), 64'(logDest_i[lane]));
      checkValue($sformatf("physDest_o[%0d]", lane), 64'(physDest_o[lane]),
                 64'(physDest_i[lane]));
      checkValue($sformatf("physSrc1_o[%0d]", lane), 64'(physSrc1_o[lane]),
                 64'(physSrc1_i[lane]));
      checkValue($sformatf("physSrc2_o[%0d]", lane), 64'(physSrc2_o[lane]),
                 64'(physSrc2_i[lane]));
    end
    checkValue("isLoad_o", 64'(isLoad_o), 64'(isLoad_i));
    checkValue("isStore_o", 64'(isStore_o), 64'(isStore_i));
  endtask

  task automatic testPassThrough();
    repeat (8) begin
      @(posedge clk);
      ctrlVerified_i <= 1'b0;
      driveRandomFields();
      @(negedge clk);
      checkPassThrough();
      checkValue("branchMask_o", 64'(branchMask_o), 64'(branchMask_i));
    end
  endtask

  task automatic testBranchMask();
    int id;
    logic [Checkpoints-1:0] expMask;
    logic [DispatchWidth-1:0][Checkpoints-1:0] masks;
    repeat (8) begin
      @(posedge clk);
      driveRandomFields();
      id = randBelow(Checkpoints);
      for (int lane = 0; lane < DispatchWidth; lane++) begin
        masks[lane] = Checkpoints'(nextRand());
        if (lane % 2 == 0) masks[lane][id] = 1'b1;  // make sure there is a bit to clear.
      end
      branchMask_i <= masks;
      ctrlVerified_i <= 1'b1;
      ctrlVerifiedId_i <= IdW'(id);
      @(negedge clk);
      for (int lane = 0; lane < DispatchWidth; lane++) begin
        expMask = branchMask_i[lane];
        expMask[id] = 1'b0;
        checkValue($sformatf("branchMask_o[%0d]", lane), 64'(branchMask_o[lane]), 64'(expMask));
      end
      @(posedge clk);
      ctrlVerified_i <= 1'b0;  // the pulse lasts one cycle.
      @(negedge clk);
      checkValue("branchMask_o", 64'(branchMask_o), 64'(branchMask_i));
    end
  endtask

  task automatic checkGroup(input int lq, input int sq, input int iq, input int al,
                            input logic [DispatchWidth-1:0] loads,
                            input logic [DispatchWidth-1:0] stores,
                            input logic ready, input logic recover);
    logic stall;
    @(posedge clk);
    loadQueueCnt_i <= LsqCntW'(lq);
    storeQueueCnt_i <= LsqCntW'(sq);
    issueQueueCnt_i <= IqCntW'(iq);
    activeListCnt_i <= AlCntW'(al);
    isLoad_i <= loads;
    isStore_i <= stores;
    renameReady_i <= ready;
    flagRecoverEX_i <= recover;
    @(negedge clk);
    stall = expectStall(lq, sq, iq, al, loads, stores);
    checkValue("stallFrontEnd_o", 64'(stallFrontEnd_o), 64'(stall));
    checkValue("backEndReady_o", 64'(backEndReady_o), 64'(!stall && ready && !recover));
  endtask

  task automatic testLoadStoreSpace();
    logic [31:0] r;
    // each queue sees the exact fit first and then one entry too many.
    checkGroup(LsqSize - DispatchWidth, 0, 0, 0, '1, '0, 1'b1, 1'b0);
    checkGroup(LsqSize - DispatchWidth + 1, 0, 0, 0, '1, '0, 1'b1, 1'b0);
    checkGroup(0, LsqSize - DispatchWidth, 0, 0, '0, '1, 1'b1, 1'b0);
    checkGroup(0, LsqSize - DispatchWidth + 1, 0, 0, '0, '1, 1'b1, 1'b0);
    checkGroup(LsqSize, LsqSize, 0, 0, '0, '0, 1'b1, 1'b0);
    repeat (24) begin
      r = nextRand();
      checkGroup(LsqSize - randBelow(DispatchWidth + 2), LsqSize - randBelow(DispatchWidth + 2),
                 0, 0, r[DispatchWidth-1:0], r[2*DispatchWidth-1:DispatchWidth], 1'b1, 1'b0);
    end
  endtask

  task automatic testIssueActiveSpace();
    logic [31:0] r;
    for (int iq = IssueQueueSize - DispatchWidth - 2; iq <= IssueQueueSize; iq++) begin
      r = nextRand();
      checkGroup(0, 0, iq, 0, '0, '0, 1'b1, 1'b0);
      checkGroup(0, 0, iq, 0, r[DispatchWidth-1:0], r[2*DispatchWidth-1:DispatchWidth],
                 1'b1, 1'b0);
    end
    for (int al = ActiveListSize - DispatchWidth - 2; al <= ActiveListSize; al++) begin
      r = nextRand();
      checkGroup(0, 0, 0, al, '0, '0, 1'b1, 1'b0);
      checkGroup(0, 0, 0, al, r[DispatchWidth-1:0], r[2*DispatchWidth-1:DispatchWidth],
                 1'b1, 1'b0);
    end
  endtask

  // the stall model ignores ready and recovery, so any coupling shows up as a mismatch.
  task automatic testReadyGating();
    logic [31:0] r;
    repeat (40) begin
      r = nextRand();
      checkGroup(randBelow(LsqSize + 1), randBelow(LsqSize + 1), randBelow(IssueQueueSize + 1),
                 randBelow(ActiveListSize + 1), r[DispatchWidth-1:0],
                 r[2*DispatchWidth-1:DispatchWidth], r[30], r[31]);
    end
  endtask

  initial begin
    driveIdle();
    waitResetRelease();
    testPassThrough();
    testBranchMask();
    testLoadStoreSpace();
    testIssueActiveSpace();
    testReadyGating();
    $display("No errors");
    $finish;
  end

endmodule

/* dispatch.f */
rtl/dispatchPkg.sv
rtl/resourceCheck.sv
rtl/branchMaskUpdate.sv
rtl/dispatch.sv
sim/dispatchTb.sv

/* Makefile */
# Verilator build of the dispatch stage and its testbench.

SRCS := $(shell grep -v '^+' dispatch.f)

.PHONY: run clean

run: obj_dir/VdispatchTb
	@out=$$(./obj_dir/VdispatchTb); echo "$$out"; echo "$$out" | grep -qx "No errors"

obj_dir/VdispatchTb: dispatch.f $(SRCS)
	verilator --binary --timing --top-module dispatchTb -f dispatch.f -o VdispatchTb

clean:
	rm -rf obj_dir
